// ==== build.f ====
+incdir+common
common/dlx_pkg.sv
control/instr_decoder.sv
control/jump_branch.sv
control/issue_control.sv
src/dlx_decode_top.sv
verification/decode_ref_model.sv
verification/tb_dlx_decode.sv

// ==== Makefile ====
TOP = tb_dlx_decode

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_dlx_decode.sv ====
`timescale 1ns/1ps
`include "dlx_defines.svh"

module tb_dlx_decode;

   import dlx_pkg::*;

   localparam int NUM_INSTR     = 3000;
   localparam int RESET_TIMEOUT = 10;
   localparam int CTRL_W        = 8 + `DLX_REG_IDX_W;

   logic                      clk;
   logic                      reset;
   logic                      instr_valid;
   logic [`DLX_INSTR_W-1:0]   instr;
   logic [`DLX_INSTR_W-1:0]   pc_plus_four;
   logic [`DLX_INSTR_W-1:0]   rs1_value;
   logic                      ex_valid;
   logic                      reg_wr;
   logic [`DLX_REG_IDX_W-1:0] ex_reg_dst;
   logic                      ex_ext_op;
   logic                      ex_alu_src;
   alu_op_e                   ex_alu_op;
   logic                      mem_wr;
   logic                      mem_to_reg;
   logic                      branch_taken;
   logic [`DLX_INSTR_W-1:0]   ex_new_pc;
   logic                      stall;
   logic                      exp_ex_valid;
   logic                      exp_reg_wr;
   logic [`DLX_REG_IDX_W-1:0] exp_reg_dst;
   logic                      exp_ext_op;
   logic                      exp_alu_src;
   alu_op_e                   exp_alu_op;
   logic                      exp_mem_wr;
   logic                      exp_mem_to_reg;
   logic                      exp_branch_taken;
   logic [`DLX_INSTR_W-1:0]   exp_new_pc;
   logic                      exp_stall;
   int                        ctrl_errors;
   int                        alu_errors;
   int                        pc_errors;
   bit                        reset_ok;

   dlx_decode_top dut (.*);
   decode_ref_model ref_model (.*);

   always #20 clk = ~clk;

   task automatic check_ctrl(input logic [CTRL_W-1:0] got, input logic [CTRL_W-1:0] exp);
      if (got !== exp) begin
         ctrl_errors++;
         $display("ERROR at %0t ns: control word %b, expected %b", $time, got, exp);
      end
   endtask

   task automatic check_alu_op(input alu_op_e got, input alu_op_e exp);
      if (got !== exp) begin
         alu_errors++;
         $display("ERROR at %0t ns: alu_op %s, expected %s", $time, got.name(), exp.name());
      end
   endtask

   task automatic check_pc(input logic [`DLX_INSTR_W-1:0] got,
                           input logic [`DLX_INSTR_W-1:0] exp);
      if (got !== exp) begin
         pc_errors++;
         $display("ERROR at %0t ns: new_pc %h, expected %h", $time, got, exp);
      end
   endtask

   // Flags in the high bits and destination register in the low bits
   always @(negedge clk) begin
      check_ctrl({ex_valid, reg_wr, mem_wr, mem_to_reg, branch_taken, stall,
                  ex_ext_op, ex_alu_src, ex_reg_dst},
                 {exp_ex_valid, exp_reg_wr, exp_mem_wr, exp_mem_to_reg, exp_branch_taken,
                  exp_stall, exp_ext_op, exp_alu_src, exp_reg_dst});
      check_alu_op(ex_alu_op, exp_alu_op);
      check_pc(ex_new_pc, exp_new_pc);
   end

   function automatic logic [5:0] random_opcode();
      case ($urandom_range(0, 21))
         0:       return opc_j;
         1:       return opc_jal;
         2:       return opc_beqz;
         3:       return opc_bnez;
         4:       return opc_addi;
         5:       return opc_addui;
         6:       return opc_subi;
         7:       return opc_subui;
         8:       return opc_lhi;
         9:       return opc_trap;
         10:      return opc_jr;
         11:      return opc_jalr;
         12:      return opc_lb;
         13:      return opc_lh;
         14:      return opc_lbu;
         15:      return opc_sb;
         16:      return opc_sh;
         17:      return opc_sw;
         18, 19:  return opc_lw;   // Extra loads for the kill path
         default: return 6'($urandom());
      endcase
   endfunction

   function automatic logic [5:0] random_func();
      case ($urandom_range(0, 13))
         0:       return func_sll;
         1:       return func_srl;
         2:       return func_sra;
         3:       return func_nop;
         4:       return func_sub;
         5:       return func_subu;
         6:       return func_add;
         7:       return func_addu;
         8:       return func_and;
         9:       return func_or;
         10:      return func_xor;
         11:      return func_slt;
         12:      return func_sgt;
         default: return 6'($urandom());
      endcase
   endfunction

   function automatic logic [`DLX_INSTR_W-1:0] random_instr();
      logic [`DLX_INSTR_W-1:0] word;
      int unsigned             pick;
      word = $urandom();
      pick = $urandom_range(0, 99);
      if (pick < 30) begin
         word[31:26] = opc_special;
         word[5:0]   = random_func();
      end else if (pick < 90) begin
         word[31:26] = random_opcode();
      end
      return word;   // Rest stays a raw random word
   endfunction

   task automatic drive_instr(input logic valid, input logic [`DLX_INSTR_W-1:0] word);
      @(posedge clk);
      instr_valid  <= valid;
      instr        <= word;
      pc_plus_four <= $urandom() & 32'hffff_fffc;
      rs1_value    <= ($urandom_range(0, 3) == 0) ? '0 : $urandom();
   endtask

   task automatic run_random(input int count);
      for (int i = 0; i < count; i++) begin
         drive_instr($urandom_range(0, 9) < 8, random_instr());
      end
   endtask

   task automatic apply_reset();
      reset       <= 1'b1;
      instr_valid <= 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic wait_idle(output bit ok);
      ok = 1'b0;
      for (int i = 0; i < RESET_TIMEOUT && !ok; i++) begin
         @(negedge clk);
         ok = ex_valid === 1'b0 && stall === 1'b0 && reg_wr === 1'b0 &&
              mem_wr === 1'b0 && branch_taken === 1'b0;
      end
   endtask

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      instr_valid  = 1'b0;
      instr        = '0;
      pc_plus_four = '0;
      rs1_value    = '0;
      ctrl_errors  = 0;
      alu_errors   = 0;
      pc_errors    = 0;
      void'($urandom(22));
      apply_reset();
      wait_idle(reset_ok);
      if (reset_ok) begin
         run_random(NUM_INSTR / 2);
         // Uses up any kill left by the random stream
         drive_instr(1'b1, {opc_addi, 26'($urandom())});
         // Unkilled load and a gap cycle, then reset while the kill is pending
         drive_instr(1'b1, {opc_lw, 26'($urandom())});
         drive_instr(1'b0, random_instr());
         drive_instr(1'b0, random_instr());
         apply_reset();
         wait_idle(reset_ok);
      end
      if (reset_ok) begin
         drive_instr(1'b1, {opc_lw, 26'($urandom())});   // Stalls as no kill is left over
         drive_instr(1'b1, {opc_lb, 26'($urandom())});   // Killed load
         run_random(NUM_INSTR / 2);
         drive_instr(1'b0, '0);
      end
      @(posedge clk);
      $display("Errors: control %0d, alu_op %0d, new_pc %0d", ctrl_errors, alu_errors, pc_errors);
      if (reset_ok && ctrl_errors + alu_errors + pc_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         if (!reset_ok) begin
            $display("Timeout: DUT outputs did not go idle within %0d cycles of reset",
                     RESET_TIMEOUT);
         end
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== verification/decode_ref_model.sv ====
`timescale 1ns/1ps
`include "dlx_defines.svh"

module decode_ref_model (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      instr_valid,
   input  logic [`DLX_INSTR_W-1:0]   instr,
   input  logic [`DLX_INSTR_W-1:0]   pc_plus_four,
   input  logic [`DLX_INSTR_W-1:0]   rs1_value,
   output logic                      exp_ex_valid,
   output logic                      exp_reg_wr,
   output logic [`DLX_REG_IDX_W-1:0] exp_reg_dst,
   output logic                      exp_ext_op,
   output logic                      exp_alu_src,
   output dlx_pkg::alu_op_e          exp_alu_op,
   output logic                      exp_mem_wr,
   output logic                      exp_mem_to_reg,
   output logic                      exp_branch_taken,
   output logic [`DLX_INSTR_W-1:0]   exp_new_pc,
   output logic                      exp_stall
);

   import dlx_pkg::*;

   logic                      kill_flag;   // Set after an unkilled load
   logic [5:0]                opc;
   alu_op_e                   op;
   logic                      r_form;
   logic                      i_form;
   logic                      load;
   logic                      store;
   logic                      link;
   logic                      writes;
   logic                      sext;
   logic [`DLX_REG_IDX_W-1:0] dst;
   logic                      taken;
   logic [`DLX_INSTR_W-1:0]   target;

   function automatic alu_op_e func_alu(input logic [5:0] f);
      case (f)
         func_add:  return alu_add;
         func_addu: return alu_addu;
         func_sub:  return alu_sub;
         func_subu: return alu_subu;
         func_and:  return alu_and;
         func_or:   return alu_or;
         func_xor:  return alu_xor;
         func_sll:  return alu_sll;
         func_srl:  return alu_srl;
         func_sra:  return alu_sra;
         func_slt:  return alu_slt;
         func_sgt:  return alu_sgt;
         default:   return alu_pass_b;   // nop and unknown codes
      endcase
   endfunction

   // Fields in descending numbering, opcode in 31:26
   assign opc = instr[31:26];

   always_comb begin
      case (opc)
         opc_special: op = func_alu(instr[5:0]);
         opc_addi:    op = alu_add;
         opc_addui:   op = alu_addu;
         opc_subi:    op = alu_sub;
         opc_subui:   op = alu_subu;
         opc_lhi:     op = alu_lhi;
         opc_lb, opc_lh, opc_lw, opc_lbu, opc_sb, opc_sh, opc_sw: op = alu_add;
         default:     op = alu_pass_b;
      endcase
      r_form = (opc == opc_special) && (op != alu_pass_b);
      load   = opc inside {opc_lb, opc_lh, opc_lw, opc_lbu};
      store  = opc inside {opc_sb, opc_sh, opc_sw};
      link   = opc inside {opc_jal, opc_jalr};
      i_form = load || store || opc inside {opc_addi, opc_addui, opc_subi, opc_subui,
                                            opc_lhi, opc_beqz, opc_bnez, opc_jr, opc_jalr};
      writes = r_form || load || link ||
               opc inside {opc_addi, opc_addui, opc_subi, opc_subui, opc_lhi};
      sext   = load || store || opc inside {opc_addi, opc_subi, opc_beqz, opc_bnez};
      dst    = link ? 5'd31 : r_form ? instr[15:11] : i_form ? instr[20:16] : '0;
      taken  = 1'b0;
      target = pc_plus_four;
      case (opc)
         opc_j, opc_jal: begin
            taken  = 1'b1;
            target = pc_plus_four + {{6{instr[25]}}, instr[25:0]};
         end
         opc_jr, opc_jalr: begin
            taken  = 1'b1;
            target = rs1_value;
         end
         opc_beqz, opc_bnez: begin
            taken = (rs1_value == '0) == (opc == opc_beqz);
            if (taken) begin
               target = pc_plus_four + {{16{instr[15]}}, instr[15:0]};
            end
         end
         default: ;
      endcase
   end

   always @(posedge clk) begin
      if (reset) begin
         kill_flag        <= 1'b0;
         exp_ex_valid     <= 1'b0;
         exp_reg_wr       <= 1'b0;
         exp_reg_dst      <= '0;
         exp_ext_op       <= 1'b0;
         exp_alu_src      <= 1'b0;
         exp_alu_op       <= alu_pass_b;
         exp_mem_wr       <= 1'b0;
         exp_mem_to_reg   <= 1'b0;
         exp_branch_taken <= 1'b0;
         exp_new_pc       <= '0;
         exp_stall        <= 1'b0;
      end else begin
         exp_ex_valid <= instr_valid;
         exp_stall    <= instr_valid && load && !kill_flag;
         if (instr_valid) begin
            kill_flag        <= load && !kill_flag;   // Killed slot clears it
            exp_reg_wr       <= writes && !kill_flag;
            exp_reg_dst      <= dst;
            exp_ext_op       <= sext;
            exp_alu_src      <= r_form;
            exp_alu_op       <= op;
            exp_mem_wr       <= store && !kill_flag;
            exp_mem_to_reg   <= load && !kill_flag;
            exp_branch_taken <= taken && !kill_flag;
            exp_new_pc       <= target;
         end
      end
   end

endmodule

// ==== src/dlx_decode_top.sv ====
`timescale 1ns/1ps
`include "dlx_defines.svh"

module dlx_decode_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      instr_valid,
   input  logic [0:`DLX_INSTR_W-1]   instr,
   input  logic [`DLX_INSTR_W-1:0]   pc_plus_four,
   input  logic [`DLX_INSTR_W-1:0]   rs1_value,
   output logic                      ex_valid,
   output logic                      reg_wr,
   output logic [`DLX_REG_IDX_W-1:0] ex_reg_dst,
   output logic                      ex_ext_op,
   output logic                      ex_alu_src,
   output dlx_pkg::alu_op_e          ex_alu_op,
   output logic                      mem_wr,
   output logic                      mem_to_reg,
   output logic                      branch_taken,
   output logic [`DLX_INSTR_W-1:0]   ex_new_pc,
   output logic                      stall
);

   import dlx_pkg::*;

   // Decoder results before the kill gating
   logic                      reg_wr_raw;
   logic [`DLX_REG_IDX_W-1:0] reg_dst;
   logic                      ext_op;
   logic                      alu_src;
   alu_op_e                   alu_op;
   logic                      mem_wr_raw;
   logic                      mem_to_reg_raw;
   logic                      is_load;

   // Resolver results
   logic [`DLX_INSTR_W-1:0]   new_pc;
   logic                      take_branch;

   instr_decoder u_decoder (
      .instr          (instr),
      .reg_wr_raw     (reg_wr_raw),
      .reg_dst        (reg_dst),
      .ext_op         (ext_op),
      .alu_src        (alu_src),
      .alu_op         (alu_op),
      .mem_wr_raw     (mem_wr_raw),
      .mem_to_reg_raw (mem_to_reg_raw),
      .is_load        (is_load)
   );

   jump_branch u_jump_branch (
      .instr        (instr),
      .pc_plus_four (pc_plus_four),
      .rs1_value    (rs1_value),
      .new_pc       (new_pc),
      .take_branch  (take_branch)
   );

   issue_control u_issue (
      .clk            (clk),
      .reset          (reset),
      .instr_valid    (instr_valid),
      .reg_wr_raw     (reg_wr_raw),
      .reg_dst        (reg_dst),
      .ext_op         (ext_op),
      .alu_src        (alu_src),
      .alu_op         (alu_op),
      .mem_wr_raw     (mem_wr_raw),
      .mem_to_reg_raw (mem_to_reg_raw),
      .is_load        (is_load),
      .take_branch    (take_branch),
      .new_pc         (new_pc),
      .ex_valid       (ex_valid),
      .reg_wr         (reg_wr),
      .ex_reg_dst     (ex_reg_dst),
      .ex_ext_op      (ex_ext_op),
      .ex_alu_src     (ex_alu_src),
      .ex_alu_op      (ex_alu_op),
      .mem_wr         (mem_wr),
      .mem_to_reg     (mem_to_reg),
      .branch_taken   (branch_taken),
      .ex_new_pc      (ex_new_pc),
      .stall          (stall)
   );

endmodule

// ==== control/issue_control.sv ====
`timescale 1ns/1ps
`include "dlx_defines.svh"

module issue_control (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      instr_valid,
   input  logic                      reg_wr_raw,
   input  logic [`DLX_REG_IDX_W-1:0] reg_dst,
   input  logic                      ext_op,
   input  logic                      alu_src,
   input  dlx_pkg::alu_op_e          alu_op,
   input  logic                      mem_wr_raw,
   input  logic                      mem_to_reg_raw,
   input  logic                      is_load,
   input  logic                      take_branch,
   input  logic [`DLX_INSTR_W-1:0]   new_pc,
   output logic                      ex_valid,
   output logic                      reg_wr,
   output logic [`DLX_REG_IDX_W-1:0] ex_reg_dst,
   output logic                      ex_ext_op,
   output logic                      ex_alu_src,
   output dlx_pkg::alu_op_e          ex_alu_op,
   output logic                      mem_wr,
   output logic                      mem_to_reg,
   output logic                      branch_taken,
   output logic [`DLX_INSTR_W-1:0]   ex_new_pc,
   output logic                      stall
);

   import dlx_pkg::*;

   logic kill_pending;   // Previous valid instruction was an unkilled load
   logic killed;
   logic load_issue;

   // Current instruction sits in the load delay slot
   assign killed     = instr_valid && kill_pending;
   assign load_issue = instr_valid && is_load && !kill_pending;

   always_ff @(posedge clk) begin
      if (reset) begin
         kill_pending <= 1'b0;
         ex_valid     <= 1'b0;
         stall        <= 1'b0;
         reg_wr       <= 1'b0;
         ex_reg_dst   <= '0;
         ex_ext_op    <= 1'b0;
         ex_alu_src   <= 1'b0;
         ex_alu_op    <= alu_pass_b;
         mem_wr       <= 1'b0;
         mem_to_reg   <= 1'b0;
         branch_taken <= 1'b0;
         ex_new_pc    <= '0;
      end else begin
         ex_valid <= instr_valid;   // One pulse per instruction
         stall    <= load_issue;
         if (instr_valid) begin
            kill_pending <= load_issue;   // Set by a load, cleared by the kill
            reg_wr       <= reg_wr_raw && !killed;
            ex_reg_dst   <= reg_dst;
            ex_ext_op    <= ext_op;
            ex_alu_src   <= alu_src;
            ex_alu_op    <= alu_op;
            mem_wr       <= mem_wr_raw && !killed;
            mem_to_reg   <= mem_to_reg_raw && !killed;
            branch_taken <= take_branch && !killed;
            ex_new_pc    <= new_pc;
         end
      end
   end

endmodule

// ==== control/jump_branch.sv ====
`timescale 1ns/1ps
`include "dlx_defines.svh"

module jump_branch (
   input  logic [0:`DLX_INSTR_W-1] instr,
   input  logic [`DLX_INSTR_W-1:0] pc_plus_four,
   input  logic [`DLX_INSTR_W-1:0] rs1_value,
   output logic [`DLX_INSTR_W-1:0] new_pc,
   output logic                    take_branch
);

   import dlx_pkg::*;

   localparam int IMM_W = `DLX_IMM_LSB - `DLX_IMM_MSB + 1;
   localparam int OFF_W = `DLX_OFF_LSB - `DLX_OFF_MSB + 1;

   opcode_e                 opc;
   logic [`DLX_INSTR_W-1:0] imm_sext;      // 16-bit branch offset
   logic [`DLX_INSTR_W-1:0] off_sext;      // 26-bit jump offset
   logic [`DLX_INSTR_W-1:0] branch_target;
   logic [`DLX_INSTR_W-1:0] jump_target;
   logic                    rs1_zero;

   assign opc = opcode_e'(instr[`DLX_OPC_MSB:`DLX_OPC_LSB]);

   assign imm_sext = {{(`DLX_INSTR_W - IMM_W){instr[`DLX_IMM_MSB]}},
                      instr[`DLX_IMM_MSB:`DLX_IMM_LSB]};
   assign off_sext = {{(`DLX_INSTR_W - OFF_W){instr[`DLX_OFF_MSB]}},
                      instr[`DLX_OFF_MSB:`DLX_OFF_LSB]};

   assign branch_target = pc_plus_four + imm_sext;
   assign jump_target   = pc_plus_four + off_sext;
   assign rs1_zero      = rs1_value == '0;

   always_comb begin
      take_branch = 1'b0;
      new_pc      = pc_plus_four;   // Fall through
      case (opc)
         opc_j, opc_jal: begin
            take_branch = 1'b1;
            new_pc      = jump_target;
         end
         opc_jr, opc_jalr: begin
            take_branch = 1'b1;
            new_pc      = rs1_value;   // Register indirect
         end
         opc_beqz: begin
            take_branch = rs1_zero;
            new_pc      = rs1_zero ? branch_target : pc_plus_four;
         end
         opc_bnez: begin
            take_branch = !rs1_zero;
            new_pc      = rs1_zero ? pc_plus_four : branch_target;
         end
         default: ;
      endcase
   end

endmodule

// ==== control/instr_decoder.sv ====
`timescale 1ns/1ps
`include "dlx_defines.svh"

module instr_decoder (
   input  logic [0:`DLX_INSTR_W-1]   instr,
   output logic                      reg_wr_raw,
   output logic [`DLX_REG_IDX_W-1:0] reg_dst,
   output logic                      ext_op,
   output logic                      alu_src,
   output dlx_pkg::alu_op_e          alu_op,
   output logic                      mem_wr_raw,
   output logic                      mem_to_reg_raw,
   output logic                      is_load
);

   import dlx_pkg::*;

   opcode_e                   opc;
   func_e                     func;
   logic [`DLX_REG_IDX_W-1:0] rd_field;
   logic [`DLX_REG_IDX_W-1:0] rs2_field;

   logic                      r_type;     // Known special function, not nop
   logic                      i_type;     // Known I-type opcode
   logic                      j_type;     // j or jal
   logic                      link;       // Writes return address to r31
   logic                      i_writes;   // I-type that writes a register
   alu_op_e                   r_alu_op;
   alu_op_e                   i_alu_op;

   assign opc       = opcode_e'(instr[`DLX_OPC_MSB:`DLX_OPC_LSB]);
   assign func      = func_e'(instr[`DLX_FUNC_MSB:`DLX_FUNC_LSB]);
   assign rd_field  = instr[`DLX_RD_MSB:`DLX_RD_LSB];
   assign rs2_field = instr[`DLX_RS2_MSB:`DLX_RS2_LSB];

   // Function field decode for R-type
   always_comb begin
      r_type   = opc == opc_special;
      r_alu_op = alu_pass_b;
      case (func)
         func_add:  r_alu_op = alu_add;
         func_addu: r_alu_op = alu_addu;
         func_sub:  r_alu_op = alu_sub;
         func_subu: r_alu_op = alu_subu;
         func_and:  r_alu_op = alu_and;
         func_or:   r_alu_op = alu_or;
         func_xor:  r_alu_op = alu_xor;
         func_sll:  r_alu_op = alu_sll;
         func_srl:  r_alu_op = alu_srl;
         func_sra:  r_alu_op = alu_sra;
         func_slt:  r_alu_op = alu_slt;
         func_sgt:  r_alu_op = alu_sgt;
         default:   r_type   = 1'b0;   // nop and unknown functions
      endcase
   end

   // Opcode decode for I-type
   always_comb begin
      i_type         = 1'b1;
      i_writes       = 1'b0;
      ext_op         = 1'b0;
      i_alu_op       = alu_pass_b;
      mem_wr_raw     = 1'b0;
      mem_to_reg_raw = 1'b0;
      is_load        = 1'b0;
      case (opc)
         opc_addi: begin
            i_writes = 1'b1;
            ext_op   = 1'b1;
            i_alu_op = alu_add;
         end
         opc_addui: begin
            i_writes = 1'b1;
            i_alu_op = alu_addu;
         end
         opc_subi: begin
            i_writes = 1'b1;
            ext_op   = 1'b1;
            i_alu_op = alu_sub;
         end
         opc_subui: begin
            i_writes = 1'b1;
            i_alu_op = alu_subu;
         end
         opc_lhi: begin
            i_writes = 1'b1;
            i_alu_op = alu_lhi;
         end
         opc_lw, opc_lh, opc_lb, opc_lbu: begin
            i_writes       = 1'b1;
            ext_op         = 1'b1;   // Signed displacement
            i_alu_op       = alu_add;
            mem_to_reg_raw = 1'b1;
            is_load        = 1'b1;
         end
         opc_sw, opc_sh, opc_sb: begin
            ext_op     = 1'b1;
            i_alu_op   = alu_add;
            mem_wr_raw = 1'b1;
         end
         opc_beqz, opc_bnez: ext_op = 1'b1;
         opc_jr:             i_writes = 1'b0;
         opc_jalr:           i_writes = 1'b1;   // Link into r31
         default:            i_type = 1'b0;   // special, j, jal, trap, undefined
      endcase
   end

   assign j_type = (opc == opc_j) || (opc == opc_jal);
   assign link   = (opc == opc_jal) || (opc == opc_jalr);

   assign reg_wr_raw = r_type || (i_type && i_writes) || (j_type && link);
   assign alu_src    = r_type;   // Second operand from register file
   assign alu_op     = r_type ? r_alu_op : i_alu_op;

   // Destination register select
   always_comb begin
      if (link) begin
         reg_dst = `DLX_LINK_REG;
      end else if (r_type) begin
         reg_dst = rd_field;
      end else if (i_type) begin
         reg_dst = rs2_field;
      end else begin
         reg_dst = '0;
      end
   end

endmodule

// ==== common/dlx_pkg.sv ====
`include "dlx_defines.svh"

package dlx_pkg;

   // Primary opcodes, instruction bits 0:5
   typedef enum logic [`DLX_OPC_W-1:0] {
      opc_special = 6'h00,   // R-type, function field selects op
      opc_j       = 6'h02,
      opc_jal     = 6'h03,
      opc_beqz    = 6'h04,
      opc_bnez    = 6'h05,
      opc_addi    = 6'h08,
      opc_addui   = 6'h09,
      opc_subi    = 6'h0a,
      opc_subui   = 6'h0b,
      opc_lhi     = 6'h0f,
      opc_trap    = 6'h11,
      opc_jr      = 6'h12,
      opc_jalr    = 6'h13,
      opc_lb      = 6'h20,
      opc_lh      = 6'h21,
      opc_lw      = 6'h23,
      opc_lbu     = 6'h24,
      opc_sb      = 6'h28,
      opc_sh      = 6'h29,
      opc_sw      = 6'h2b
   } opcode_e;

   // Function codes for opc_special, instruction bits 26:31
   typedef enum logic [`DLX_OPC_W-1:0] {
      func_sll  = 6'h04,
      func_srl  = 6'h06,
      func_sra  = 6'h07,
      func_nop  = 6'h15,
      func_sub  = 6'h18,
      func_subu = 6'h19,
      func_add  = 6'h20,
      func_addu = 6'h21,
      func_and  = 6'h24,
      func_or   = 6'h25,
      func_xor  = 6'h26,
      func_slt  = 6'h28,
      func_sgt  = 6'h2b
   } func_e;

   // ALU operations seen by the execute stage
   typedef enum logic [`DLX_ALU_OP_W-1:0] {
      alu_pass_b = 4'h0,   // Also the idle value
      alu_add    = 4'h1,
      alu_addu   = 4'h2,
      alu_sub    = 4'h3,
      alu_subu   = 4'h4,
      alu_and    = 4'h5,
      alu_or     = 4'h6,
      alu_xor    = 4'h7,
      alu_sll    = 4'h8,
      alu_srl    = 4'h9,
      alu_sra    = 4'ha,
      alu_slt    = 4'hb,
      alu_sgt    = 4'hc,
      alu_lhi    = 4'hd    // Immediate into upper half
   } alu_op_e;

endpackage

// ==== common/dlx_defines.svh ====
`ifndef DLX_DEFINES_SVH
`define DLX_DEFINES_SVH

// Datapath widths
`define DLX_INSTR_W     32
`define DLX_REG_IDX_W   5
`define DLX_ALU_OP_W    4
`define DLX_OPC_W       6

// Field positions, bit 0 is the instruction MSB
`define DLX_OPC_MSB     0
`define DLX_OPC_LSB     5
`define DLX_RS1_MSB     6
`define DLX_RS1_LSB     10
`define DLX_RS2_MSB     11
`define DLX_RS2_LSB     15
`define DLX_RD_MSB      16
`define DLX_RD_LSB      20
`define DLX_FUNC_MSB    26
`define DLX_FUNC_LSB    31
`define DLX_IMM_MSB     16
`define DLX_IMM_LSB     31
`define DLX_OFF_MSB     6
`define DLX_OFF_LSB     31

`define DLX_LINK_REG    5'd31

`endif
